/* all.f */
verilog/cpu_pkg.sv
verilog/register_file.sv
verilog/stage_if.sv
verilog/stage_id.sv
verilog/stage_ex.sv
verilog/stage_mem.sv
verilog/cpu_core.sv
tb/cpu_checker.sv
tb/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/register_file.sv
      - verilog/stage_if.sv
      - verilog/stage_id.sv
      - verilog/stage_ex.sv
      - verilog/stage_mem.sv
      - verilog/cpu_core.sv
  - target: test
    files:
      - tb/cpu_checker.sv
      - tb/tb_cpu.sv

/* tb/tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu;

	logic clk;
	logic rst;
	logic imem_we;
	logic [cpu_pkg::IMEM_AW-1:0] imem_addr;
	logic [31:0] imem_data;
	logic retire_valid;
	logic [4:0] retire_addr;
	logic [31:0] retire_data;
	logic invalid_pulse;
	logic [31:0] invalid_pc;

	// Program table, one row per instruction word
	logic [31:0] prog_word [$];
	bit prog_wr [$];
	logic [4:0] prog_reg [$];
	logic [31:0] prog_val [$];
	logic [31:0] bad_pc [$];	// Words that must raise invalid_pulse
	logic [31:0] model_reg [32];
	logic [31:0] model_mem [cpu_pkg::DMEM_WORDS];

	cpu_core u_dut (
		.clk(clk), .rst(rst),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.retire_valid(retire_valid), .retire_addr(retire_addr), .retire_data(retire_data),
		.invalid_pulse(invalid_pulse), .invalid_pc(invalid_pc)
	);

	cpu_checker u_chk (
		.clk(clk), .rst(rst),
		.retire_valid(retire_valid), .retire_addr(retire_addr), .retire_data(retire_data),
		.invalid_pulse(invalid_pulse), .invalid_pc(invalid_pc)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] r_word(input cpu_pkg::funct_e fn,
		input logic [4:0] rd, rs, rt, sa);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] i_word(input cpu_pkg::opcode_e op,
		input logic [4:0] rt, rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Writes to r0 are dropped by the ISA
	task automatic add_row(input logic [31:0] word, input bit wr, input logic [4:0] rd,
		input logic [31:0] val);
		prog_word.push_back(word);
		prog_wr.push_back(wr && rd != 5'd0);
		prog_reg.push_back(rd);
		prog_val.push_back(val);
		if (wr && rd != 5'd0)
			model_reg[rd] = val;
	endtask

	task automatic reg_op(input cpu_pkg::funct_e fn, input logic [4:0] rd, rs, rt, sa);
		logic [31:0] a, b, res;
		a = model_reg[rs];
		b = model_reg[rt];
		case (fn)
			cpu_pkg::fn_addu: res = a + b;
			cpu_pkg::fn_subu: res = a - b;
			cpu_pkg::fn_and: res = a & b;
			cpu_pkg::fn_or: res = a | b;
			cpu_pkg::fn_xor: res = a ^ b;
			cpu_pkg::fn_slt: res = {31'h0, $signed(a) < $signed(b)};
			cpu_pkg::fn_sltu: res = {31'h0, a < b};
			cpu_pkg::fn_sll: res = b << sa;
			default: res = b >> sa;	// SRL
		endcase
		add_row(r_word(fn, rd, rs, rt, sa), 1'b1, rd, res);
	endtask

	task automatic imm_op(input cpu_pkg::opcode_e op, input logic [4:0] rt, rs,
		input logic [15:0] imm);
		logic [31:0] a, sext, zext, res;
		a = model_reg[rs];
		sext = {{16{imm[15]}}, imm};
		zext = {16'h0, imm};
		case (op)
			cpu_pkg::op_addiu: res = a + sext;
			cpu_pkg::op_slti: res = {31'h0, $signed(a) < $signed(sext)};
			cpu_pkg::op_sltiu: res = {31'h0, a < sext};
			cpu_pkg::op_andi: res = a & zext;
			cpu_pkg::op_ori: res = a | zext;
			cpu_pkg::op_xori: res = a ^ zext;
			default: res = {imm, 16'h0};	// LUI
		endcase
		add_row(i_word(op, rt, rs, imm), 1'b1, rt, res);
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
		imm_op(cpu_pkg::op_lui, rd, 5'd0, val[31:16]);
		imm_op(cpu_pkg::op_ori, rd, rd, val[15:0]);
	endtask

	task automatic store_word(input logic [4:0] rt, rs, input logic [15:0] off);
		logic [31:0] addr;
		addr = model_reg[rs] + {{16{off[15]}}, off};
		model_mem[addr[cpu_pkg::DMEM_AW+1:2]] = model_reg[rt];
		add_row(i_word(cpu_pkg::op_sw, rt, rs, off), 1'b0, 5'd0, 32'h0);
	endtask

	task automatic load_word(input logic [4:0] rt, rs, input logic [15:0] off);
		logic [31:0] addr;
		addr = model_reg[rs] + {{16{off[15]}}, off};
		add_row(i_word(cpu_pkg::op_lw, rt, rs, off), 1'b1, rt,
			model_mem[addr[cpu_pkg::DMEM_AW+1:2]]);
	endtask

	// Delay slot bumps r10, the word after it bumps r11 unless jumped over
	task automatic after_branch(input bit taken);
		imm_op(cpu_pkg::op_addiu, 5'd10, 5'd10, 16'd1);
		if (taken)
			add_row(i_word(cpu_pkg::op_addiu, 5'd11, 5'd11, 16'd1), 1'b0, 5'd0, 32'h0);
		else
			imm_op(cpu_pkg::op_addiu, 5'd11, 5'd11, 16'd1);
	endtask

	task automatic branch_case(input cpu_pkg::opcode_e op, input logic [4:0] rs, rt);
		logic [31:0] a;
		bit taken;
		a = model_reg[rs];
		case (op)
			cpu_pkg::op_beq: taken = (a == model_reg[rt]);
			cpu_pkg::op_bne: taken = (a != model_reg[rt]);
			cpu_pkg::op_blez: taken = ($signed(a) <= 0);
			cpu_pkg::op_bgtz: taken = ($signed(a) > 0);
			default: taken = rt[0] ? ($signed(a) >= 0) : ($signed(a) < 0);	// BGEZ, BLTZ
		endcase
		add_row(i_word(op, rt, rs, 16'd2), 1'b0, 5'd0, 32'h0);	// Target is 3 words on
		after_branch(taken);
	endtask

	task automatic jump_case(input cpu_pkg::opcode_e op);
		int here;
		here = prog_word.size();
		add_row({op, 26'(here + 3)}, op == cpu_pkg::op_jal, 5'd31, 32'(here * 4 + 8));
		after_branch(1'b1);
	endtask

	// Zero link register means JR
	task automatic jump_reg_case(input logic [4:0] link);
		int here;
		here = prog_word.size();
		imm_op(cpu_pkg::op_addiu, 5'd5, 5'd0, 16'((here + 4) * 4));
		add_row(r_word(link == 5'd0 ? cpu_pkg::fn_jr : cpu_pkg::fn_jalr, link, 5'd5, 5'd0,
			5'd0), link != 5'd0, link, 32'((here + 1) * 4 + 8));
		after_branch(1'b1);
	endtask

	task automatic invalid_word(input logic [31:0] word);
		bad_pc.push_back(32'(prog_word.size() * 4));
		add_row(word, 1'b0, 5'd0, 32'h0);
	endtask

	task automatic test_marker(input int n);
		imm_op(cpu_pkg::op_addiu, 5'd30, 5'd0, 16'(n));
	endtask

	task automatic build_program();
		int here;
		load_const(5'd1, $urandom());
		load_const(5'd2, $urandom());
		load_const(5'd3, $urandom() | 32'h8000_0000);	// Negative
		imm_op(cpu_pkg::op_addiu, 5'd4, 5'd0, 16'hfff9);
		reg_op(cpu_pkg::fn_addu, 5'd12, 5'd1, 5'd2, 5'd0);
		reg_op(cpu_pkg::fn_subu, 5'd13, 5'd1, 5'd3, 5'd0);
		reg_op(cpu_pkg::fn_and, 5'd14, 5'd1, 5'd2, 5'd0);
		reg_op(cpu_pkg::fn_or, 5'd15, 5'd2, 5'd3, 5'd0);
		reg_op(cpu_pkg::fn_xor, 5'd16, 5'd1, 5'd3, 5'd0);
		reg_op(cpu_pkg::fn_slt, 5'd17, 5'd3, 5'd1, 5'd0);
		reg_op(cpu_pkg::fn_slt, 5'd18, 5'd4, 5'd3, 5'd0);
		reg_op(cpu_pkg::fn_sltu, 5'd19, 5'd3, 5'd1, 5'd0);
		reg_op(cpu_pkg::fn_sll, 5'd20, 5'd0, 5'd1, 5'd7);
		reg_op(cpu_pkg::fn_srl, 5'd21, 5'd0, 5'd3, 5'd5);
		imm_op(cpu_pkg::op_addiu, 5'd22, 5'd3, 16'hfff9);
		imm_op(cpu_pkg::op_slti, 5'd23, 5'd4, 16'hfffd);
		imm_op(cpu_pkg::op_sltiu, 5'd24, 5'd4, 16'hffff);
		imm_op(cpu_pkg::op_andi, 5'd25, 5'd3, 16'hf0f0);
		imm_op(cpu_pkg::op_xori, 5'd26, 5'd1, 16'hffff);
		test_marker(1);
		reg_op(cpu_pkg::fn_subu, 5'd12, 5'd1, 5'd2, 5'd0);	// Forwarding chain
		reg_op(cpu_pkg::fn_addu, 5'd13, 5'd12, 5'd12, 5'd0);
		reg_op(cpu_pkg::fn_xor, 5'd14, 5'd12, 5'd13, 5'd0);
		reg_op(cpu_pkg::fn_subu, 5'd15, 5'd14, 5'd12, 5'd0);
		reg_op(cpu_pkg::fn_or, 5'd16, 5'd15, 5'd13, 5'd0);
		reg_op(cpu_pkg::fn_sll, 5'd17, 5'd0, 5'd16, 5'd3);
		test_marker(2);
		imm_op(cpu_pkg::op_addiu, 5'd21, 5'd0, 16'h0040);
		store_word(5'd1, 5'd21, 16'd0);
		load_word(5'd22, 5'd21, 16'd0);
		store_word(5'd2, 5'd21, 16'd4);
		load_word(5'd23, 5'd21, 16'd4);
		reg_op(cpu_pkg::fn_addu, 5'd24, 5'd23, 5'd23, 5'd0);	// Load-use
		load_word(5'd25, 5'd21, 16'd0);
		imm_op(cpu_pkg::op_addiu, 5'd26, 5'd25, 16'd1);
		test_marker(3);
		imm_op(cpu_pkg::op_addiu, 5'd6, 5'd0, 16'd5);
		imm_op(cpu_pkg::op_addiu, 5'd7, 5'd0, 16'd5);
		imm_op(cpu_pkg::op_addiu, 5'd8, 5'd0, 16'hfffd);
		branch_case(cpu_pkg::op_beq, 5'd6, 5'd7);
		branch_case(cpu_pkg::op_beq, 5'd6, 5'd8);
		branch_case(cpu_pkg::op_bne, 5'd6, 5'd8);
		branch_case(cpu_pkg::op_bne, 5'd6, 5'd7);
		branch_case(cpu_pkg::op_blez, 5'd8, 5'd0);
		branch_case(cpu_pkg::op_blez, 5'd6, 5'd0);
		branch_case(cpu_pkg::op_blez, 5'd0, 5'd0);
		branch_case(cpu_pkg::op_bgtz, 5'd6, 5'd0);
		branch_case(cpu_pkg::op_bgtz, 5'd8, 5'd0);
		branch_case(cpu_pkg::op_regimm, 5'd8, 5'd0);
		branch_case(cpu_pkg::op_regimm, 5'd6, 5'd0);
		branch_case(cpu_pkg::op_regimm, 5'd6, 5'd1);
		branch_case(cpu_pkg::op_regimm, 5'd0, 5'd1);
		branch_case(cpu_pkg::op_regimm, 5'd8, 5'd1);
		test_marker(4);
		jump_case(cpu_pkg::op_j);
		jump_case(cpu_pkg::op_jal);
		jump_reg_case(5'd0);
		jump_reg_case(5'd6);
		test_marker(5);
		invalid_word({6'h3f, 26'h0});
		invalid_word({6'h00, 5'd1, 5'd2, 5'd12, 5'd0, 6'h3f});
		invalid_word({cpu_pkg::op_regimm, 5'd1, 5'd2, 16'h0});
		imm_op(cpu_pkg::op_addiu, 5'd0, 5'd0, 16'h1234);
		reg_op(cpu_pkg::fn_addu, 5'd0, 5'd1, 5'd2, 5'd0);
		reg_op(cpu_pkg::fn_addu, 5'd12, 5'd0, 5'd1, 5'd0);
		test_marker(6);
		here = prog_word.size();	// Park the core in a jump to itself
		add_row({cpu_pkg::op_j, 26'(here)}, 1'b0, 5'd0, 32'h0);
		add_row(32'h0, 1'b0, 5'd0, 32'h0);
		add_row(32'h0, 1'b0, 5'd0, 32'h0);
	endtask

	task automatic print_counts();
		$display("Summary: %0d tests passing, %0d failing, %0d write-backs checked, %0d errors",
			u_chk.tests_passed, u_chk.tests_failed, u_chk.checked, u_chk.errors);
	endtask

	initial begin
		rst = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = 32'h0;
		void'($urandom(32'hfd02));
		for (int i = 0; i < 32; i++)
			model_reg[i] = 32'h0;
		build_program();
		for (int i = 0; i < prog_word.size(); i++) begin
			@(posedge clk);
			#2;
			imem_we = 1'b1;
			imem_addr = i[cpu_pkg::IMEM_AW-1:0];
			imem_data = prog_word[i];
			if (prog_wr[i])
				u_chk.expect_write(prog_reg[i], prog_val[i], prog_reg[i] == 5'd30);
		end
		@(posedge clk);
		#2;
		imem_we = 1'b0;
		foreach (bad_pc[i])
			u_chk.expect_invalid(bad_pc[i]);
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		while (u_chk.pending() != 0)
			@(posedge clk);
		repeat (10) @(posedge clk);	// Catch any stray write-back
		print_counts();
		if (u_chk.errors == 0 && u_chk.tests_failed == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Four cycles per row covers stalls and branch bubbles
	initial begin
		@(negedge rst);
		repeat (prog_word.size() * 4 + 100) @(posedge clk);
		$display("Watchdog expired after %0d cycles, these results never arrived:",
			prog_word.size() * 4 + 100);
		u_chk.report_missing();
		print_counts();
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* tb/cpu_checker.sv */
`timescale 1ns/10ps

// Compares the core's write-backs and invalid pulses with the expected stream
module cpu_checker (
	input logic clk,
	input logic rst,
	input logic retire_valid,
	input logic [4:0] retire_addr,
	input logic [31:0] retire_data,
	input logic invalid_pulse,
	input logic [31:0] invalid_pc
);

	logic [4:0] exp_reg [$];
	logic [31:0] exp_val [$];
	bit exp_marker [$];	// Last write of a test section
	logic [31:0] exp_pc [$];
	int errors = 0;
	int checked = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int test_errs = 0;

	task automatic expect_write(input logic [4:0] rd, input logic [31:0] val,
		input bit marker);
		exp_reg.push_back(rd);
		exp_val.push_back(val);
		exp_marker.push_back(marker);
	endtask

	task automatic expect_invalid(input logic [31:0] pc);
		exp_pc.push_back(pc);
	endtask

	function automatic int pending();
		return exp_reg.size() + exp_pc.size();
	endfunction

	task automatic report_missing();
		foreach (exp_reg[i])
			$display("  write-back of r%0d = %h never retired", exp_reg[i], exp_val[i]);
		foreach (exp_pc[i])
			$display("  invalid word at pc %h was never flagged", exp_pc[i]);
	endtask

	task automatic error_seen();
		errors++;
		test_errs++;
	endtask

	task automatic check_write();
		logic [4:0] rd;
		logic [31:0] val;
		bit marker;
		if (exp_reg.size() == 0) begin
			$display("Unexpected write-back at %0t: r%0d = %h with nothing left to retire",
				$time, retire_addr, retire_data);
			error_seen();
		end else begin
			rd = exp_reg.pop_front();
			val = exp_val.pop_front();
			marker = exp_marker.pop_front();
			checked++;
			if (retire_addr !== rd || retire_data !== val) begin
				$display("Fail at %0t: wrote r%0d = %h, expected r%0d = %h",
					$time, retire_addr, retire_data, rd, val);
				error_seen();
			end
			if (marker) begin
				if (test_errs == 0) begin
					tests_passed++;
					$display("Test %0d pass at %0t", val, $time);
				end else begin
					tests_failed++;
					$display("Test %0d fail with %0d errors", val, test_errs);
				end
				test_errs = 0;
			end
		end
	endtask

	task automatic check_invalid();
		logic [31:0] pc;
		if (exp_pc.size() == 0) begin
			$display("Unexpected invalid instruction pulse at %0t for pc %h",
				$time, invalid_pc);
			error_seen();
		end else begin
			pc = exp_pc.pop_front();
			if (invalid_pc !== pc) begin
				$display("Fail at %0t: invalid pulse for pc %h, expected pc %h",
					$time, invalid_pc, pc);
				error_seen();
			end
		end
	endtask

	// Registered DUT outputs, read at the edge before they update
	always @(posedge clk) begin
		if (!rst && retire_valid)
			check_write();
		if (!rst && invalid_pulse)
			check_invalid();
	end

endmodule

/* verilog/cpu_core.sv */
`timescale 1ns/10ps

// Five-stage core top level
module cpu_core (
	input logic clk,
	input logic rst,
	input logic imem_we,
	input logic [cpu_pkg::IMEM_AW-1:0] imem_addr,
	input logic [31:0] imem_data,
	output logic retire_valid,
	output logic [4:0] retire_addr,
	output logic [31:0] retire_data,
	output logic invalid_pulse,
	output logic [31:0] invalid_pc
);

	logic [31:0] instr, next_pc, branch_target;
	logic stall, branch_taken, if_branch;
	logic [4:0] reg1_addr, reg2_addr, wb_addr_id, wb_addr_ex;
	logic [31:0] reg1_data, reg2_data, sa_imm;
	cpu_pkg::alu_op_e alu_op;
	cpu_pkg::alu_src_e alu_src;
	cpu_pkg::branch_op_e branch_op;
	logic [32:0] branch_dest;
	cpu_pkg::mem_op_e mem_op_id, mem_op_ex;
	logic [31:0] alu_result, store_data;

	stage_if u_if (
		.clk(clk), .rst(rst),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.stall(stall),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.instr(instr), .next_pc(next_pc)
	);

	// Load-use check looks at the word now in execute
	stage_id u_id (
		.clk(clk), .rst(rst),
		.instr(instr), .next_pc(next_pc), .cur_if_branch(if_branch),
		.clear(branch_taken),
		.ex_mem_op(mem_op_id), .ex_wb_addr(wb_addr_id),
		.reg_write_addr(retire_addr), .reg_write_data(retire_data),
		.reg1_addr(reg1_addr), .reg1_data(reg1_data),
		.reg2_addr(reg2_addr), .reg2_data(reg2_data),
		.alu_op(alu_op), .alu_src(alu_src), .sa_imm(sa_imm),
		.branch_op(branch_op), .branch_dest(branch_dest),
		.mem_op(mem_op_id), .wb_addr(wb_addr_id),
		.stall(stall), .if_branch(if_branch),
		.invalid_pulse(invalid_pulse), .invalid_pc(invalid_pc)
	);

	stage_ex u_ex (
		.clk(clk), .rst(rst),
		.reg1_addr(reg1_addr), .reg1_data(reg1_data),
		.reg2_addr(reg2_addr), .reg2_data(reg2_data),
		.alu_op(alu_op), .alu_src(alu_src), .sa_imm(sa_imm),
		.branch_op(branch_op), .branch_dest(branch_dest),
		.mem_op(mem_op_id), .wb_addr(wb_addr_id),
		.wb_addr_mem(retire_addr), .wb_data_mem(retire_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.alu_result(alu_result), .store_data(store_data),
		.mem_op_out(mem_op_ex), .wb_addr_out(wb_addr_ex)
	);

	stage_mem u_mem (
		.clk(clk), .rst(rst),
		.alu_result(alu_result), .store_data(store_data),
		.mem_op(mem_op_ex), .wb_addr_in(wb_addr_ex),
		.wb_addr(retire_addr), .wb_data(retire_data),
		.retire_valid(retire_valid)
	);

endmodule

/* verilog/stage_mem.sv */
`timescale 1ns/10ps

// Memory access and the MEM/WB register
module stage_mem (
	input logic clk,
	input logic rst,
	input logic [31:0] alu_result,	// Address for loads and stores
	input logic [31:0] store_data,
	input cpu_pkg::mem_op_e mem_op,
	input logic [4:0] wb_addr_in,
	output logic [4:0] wb_addr,
	output logic [31:0] wb_data,
	output logic retire_valid
);

	logic [31:0] dmem [cpu_pkg::DMEM_WORDS];
	logic [cpu_pkg::DMEM_AW-1:0] word_addr;

	assign word_addr = alu_result[cpu_pkg::DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (mem_op == cpu_pkg::mem_sw)
			dmem[word_addr] <= store_data;
	end

	always_ff @(posedge clk) begin
		wb_data <= (mem_op == cpu_pkg::mem_lw) ? dmem[word_addr] : alu_result;
	end

	// Stores, branches and bubbles carry r0
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_addr <= 5'd0;
			retire_valid <= 1'b0;
		end else begin
			wb_addr <= wb_addr_in;
			retire_valid <= (wb_addr_in != 5'd0);
		end
	end

endmodule

/* verilog/stage_ex.sv */
`timescale 1ns/10ps

// Execute: forwarding, ALU, branch resolution and the EX/MEM register
module stage_ex (
	input logic clk,
	input logic rst,
	input logic [4:0] reg1_addr,
	input logic [31:0] reg1_data,
	input logic [4:0] reg2_addr,
	input logic [31:0] reg2_data,
	input cpu_pkg::alu_op_e alu_op,
	input cpu_pkg::alu_src_e alu_src,
	input logic [31:0] sa_imm,
	input cpu_pkg::branch_op_e branch_op,
	input logic [32:0] branch_dest,
	input cpu_pkg::mem_op_e mem_op,
	input logic [4:0] wb_addr,
	input logic [4:0] wb_addr_mem,	// Write-back stage result
	input logic [31:0] wb_data_mem,
	output logic branch_taken,
	output logic [31:0] branch_target,
	output logic [31:0] alu_result,
	output logic [31:0] store_data,
	output cpu_pkg::mem_op_e mem_op_out,
	output logic [4:0] wb_addr_out
);

	logic [31:0] opr1, opr2_reg, opr2, result;
	logic take;

	// Newer result first, r0 never forwarded
	function automatic logic [31:0] forward(input logic [4:0] addr, input logic [31:0] data);
		if (addr != 5'd0 && addr == wb_addr_out)
			return alu_result;
		if (addr != 5'd0 && addr == wb_addr_mem)
			return wb_data_mem;
		return data;
	endfunction

	always_comb begin
		opr1 = forward(reg1_addr, reg1_data);
		opr2_reg = forward(reg2_addr, reg2_data);
		opr2 = (alu_src == cpu_pkg::src_imm) ? sa_imm : opr2_reg;
		case (alu_op)
			cpu_pkg::alu_addu: result = opr1 + opr2;
			cpu_pkg::alu_subu: result = opr1 - opr2;
			cpu_pkg::alu_and: result = opr1 & opr2;
			cpu_pkg::alu_or: result = opr1 | opr2;
			cpu_pkg::alu_xor: result = opr1 ^ opr2;
			cpu_pkg::alu_lt: result = {31'h0, $signed(opr1) < $signed(opr2)};
			cpu_pkg::alu_ltu: result = {31'h0, opr1 < opr2};
			cpu_pkg::alu_sll: result = opr2 << sa_imm[4:0];
			cpu_pkg::alu_srl: result = opr2 >> sa_imm[4:0];
			cpu_pkg::alu_setu: result = opr2;
			cpu_pkg::alu_pass_opr1: result = opr1;
			default: result = 32'h0;
		endcase
		case (branch_op)
			cpu_pkg::br_uncond: take = 1'b1;
			cpu_pkg::br_on_alu_eqz: take = (result == 32'h0);
			cpu_pkg::br_on_alu_nez: take = (result != 32'h0);
			default: take = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			branch_taken <= 1'b0;
			mem_op_out <= cpu_pkg::mem_none;
			wb_addr_out <= 5'd0;
		end else begin
			branch_taken <= take;
			mem_op_out <= mem_op;
			wb_addr_out <= wb_addr;
		end
	end

	always_ff @(posedge clk) begin
		alu_result <= result;
		store_data <= opr2_reg;
		branch_target <= branch_dest[32] ? opr2_reg : branch_dest[31:0];
	end

	// A branch can never sit in the delay slot of a taken branch
	a_taken_single_cycle: assert property (@(posedge clk) disable iff (rst)
		branch_taken |=> !branch_taken)
		else $error("branch_taken high in two consecutive cycles");

endmodule

/* verilog/stage_id.sv */
`timescale 1ns/10ps

// Decode and the ID/EX register
module stage_id (
	input logic clk,
	input logic rst,
	input logic [31:0] instr,
	input logic [31:0] next_pc,
	input logic cur_if_branch,	// Word in decode is a delay slot
	input logic clear,
	input cpu_pkg::mem_op_e ex_mem_op,
	input logic [4:0] ex_wb_addr,
	input logic [4:0] reg_write_addr,
	input logic [31:0] reg_write_data,
	output logic [4:0] reg1_addr,
	output logic [31:0] reg1_data,
	output logic [4:0] reg2_addr,
	output logic [31:0] reg2_data,
	output cpu_pkg::alu_op_e alu_op,
	output cpu_pkg::alu_src_e alu_src,
	output logic [31:0] sa_imm,
	output cpu_pkg::branch_op_e branch_op,
	output logic [32:0] branch_dest,	// Bit 32 takes the target from operand two
	output cpu_pkg::mem_op_e mem_op,
	output logic [4:0] wb_addr,
	output logic stall,
	output logic if_branch,
	output logic invalid_pulse,
	output logic [31:0] invalid_pc
);

	logic [31:0] rf_data1, rf_data2;
	cpu_pkg::opcode_e opcode;
	cpu_pkg::funct_e funct;
	logic [4:0] rs, rt, rd;
	logic [31:0] imm_sext, imm_zext;
	logic [32:0] dest_rel, dest_region;
	logic is_branch;
	logic drop;

	assign opcode = cpu_pkg::opcode_e'(instr[31:26]);
	assign funct = cpu_pkg::funct_e'(instr[5:0]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm_sext = {{16{instr[15]}}, instr[15:0]};
	assign imm_zext = {16'h0, instr[15:0]};

	// Offsets count from the delay slot address
	assign dest_rel = {1'b0, next_pc + {imm_sext[29:0], 2'b00}};
	assign dest_region = {1'b0, next_pc[31:28], instr[25:0], 2'b00};

	assign is_branch = opcode inside {cpu_pkg::op_regimm, cpu_pkg::op_j, cpu_pkg::op_jal,
		cpu_pkg::op_beq, cpu_pkg::op_bne, cpu_pkg::op_blez, cpu_pkg::op_bgtz} ||
		(opcode == cpu_pkg::op_special && funct inside {cpu_pkg::fn_jr, cpu_pkg::fn_jalr});

	// A delay slot is never thrown away
	assign drop = clear && !cur_if_branch;

	// Load in execute feeding the word in decode
	assign stall = !drop && ex_mem_op == cpu_pkg::mem_lw && ex_wb_addr != 5'd0 &&
		(ex_wb_addr == rs || ex_wb_addr == rt);

	register_file u_regfile (
		.clk(clk),
		.rst(rst),
		.read1_addr(rs),
		.read2_addr(rt),
		.write_addr(reg_write_addr),
		.data_in(reg_write_data),
		.data_out1(rf_data1),
		.data_out2(rf_data2)
	);

	task set_bubble();
		reg1_addr <= 5'd0;
		reg1_data <= 32'h0;
		reg2_addr <= 5'd0;
		reg2_data <= 32'h0;
		alu_op <= cpu_pkg::alu_disable;
		alu_src <= cpu_pkg::src_reg;
		sa_imm <= 32'h0;
		branch_op <= cpu_pkg::br_none;
		branch_dest <= 33'h0;
		mem_op <= cpu_pkg::mem_none;
		wb_addr <= 5'd0;
	endtask

	task read_rs();
		reg1_addr <= rs;
		reg1_data <= rf_data1;
	endtask

	task read_rt();
		reg2_addr <= rt;
		reg2_data <= rf_data2;
	endtask

	task rs_as_opr2();
		reg2_addr <= rs;
		reg2_data <= rf_data1;
	endtask

	task rtype(input cpu_pkg::alu_op_e op);
		read_rs();
		read_rt();
		alu_op <= op;
		sa_imm <= {27'h0, instr[10:6]};	// Shift amount
		wb_addr <= rd;
	endtask

	task alu_imm(input cpu_pkg::alu_op_e op, input logic [31:0] imm);
		alu_src <= cpu_pkg::src_imm;
		alu_op <= op;
		sa_imm <= imm;
	endtask

	task wb_imm(input cpu_pkg::alu_op_e op, input logic [31:0] imm);
		read_rs();
		alu_imm(op, imm);
		wb_addr <= rt;
	endtask

	task cond_branch(input cpu_pkg::alu_op_e op, input cpu_pkg::branch_op_e cond);
		alu_op <= op;
		branch_op <= cond;
		branch_dest <= dest_rel;
	endtask

	task mem_access(input cpu_pkg::mem_op_e op);
		read_rs();
		read_rt();
		alu_imm(cpu_pkg::alu_addu, imm_sext);
		mem_op <= op;
		if (op == cpu_pkg::mem_lw)
			wb_addr <= rt;
	endtask

	task jump_region();
		branch_op <= cpu_pkg::br_uncond;
		branch_dest <= dest_region;
	endtask

	task jump_reg();
		branch_op <= cpu_pkg::br_uncond;
		branch_dest <= {1'b1, 32'h0};
		rs_as_opr2();
	endtask

	// Return address skips the delay slot
	task link(input logic [4:0] dest);
		reg1_data <= next_pc + 32'd4;
		alu_op <= cpu_pkg::alu_pass_opr1;
		wb_addr <= dest;
	endtask

	task mark_invalid();
		invalid_pulse <= 1'b1;
		invalid_pc <= next_pc - 32'd4;
	endtask

	task do_decode();
		case (opcode)
			cpu_pkg::op_special:
				case (funct)
					cpu_pkg::fn_sll: rtype(cpu_pkg::alu_sll);
					cpu_pkg::fn_srl: rtype(cpu_pkg::alu_srl);
					cpu_pkg::fn_jr: jump_reg();
					cpu_pkg::fn_jalr: begin
						jump_reg();
						link(rd);
					end
					cpu_pkg::fn_addu: rtype(cpu_pkg::alu_addu);
					cpu_pkg::fn_subu: rtype(cpu_pkg::alu_subu);
					cpu_pkg::fn_and: rtype(cpu_pkg::alu_and);
					cpu_pkg::fn_or: rtype(cpu_pkg::alu_or);
					cpu_pkg::fn_xor: rtype(cpu_pkg::alu_xor);
					cpu_pkg::fn_slt: rtype(cpu_pkg::alu_lt);
					cpu_pkg::fn_sltu: rtype(cpu_pkg::alu_ltu);
					default: mark_invalid();
				endcase
			cpu_pkg::op_regimm:
				if (rt == 5'd1 || rt == 5'd0) begin
					read_rs();	// rs < 0, BGEZ on zero result and BLTZ otherwise
					cond_branch(cpu_pkg::alu_lt,
						rt[0] ? cpu_pkg::br_on_alu_eqz : cpu_pkg::br_on_alu_nez);
				end else begin
					mark_invalid();
				end
			cpu_pkg::op_j: jump_region();
			cpu_pkg::op_jal: begin
				jump_region();
				link(5'd31);
			end
			cpu_pkg::op_beq: begin
				read_rs();
				read_rt();
				cond_branch(cpu_pkg::alu_xor, cpu_pkg::br_on_alu_eqz);
			end
			cpu_pkg::op_bne: begin
				read_rs();
				read_rt();
				cond_branch(cpu_pkg::alu_xor, cpu_pkg::br_on_alu_nez);
			end
			cpu_pkg::op_blez, cpu_pkg::op_bgtz:
				if (rt == 5'd0) begin
					rs_as_opr2();	// Tests 0 < rs
					cond_branch(cpu_pkg::alu_lt, (opcode == cpu_pkg::op_blez) ?
						cpu_pkg::br_on_alu_eqz : cpu_pkg::br_on_alu_nez);
				end else begin
					mark_invalid();
				end
			cpu_pkg::op_addiu: wb_imm(cpu_pkg::alu_addu, imm_sext);
			cpu_pkg::op_slti: wb_imm(cpu_pkg::alu_lt, imm_sext);
			cpu_pkg::op_sltiu: wb_imm(cpu_pkg::alu_ltu, imm_sext);
			cpu_pkg::op_andi: wb_imm(cpu_pkg::alu_and, imm_zext);
			cpu_pkg::op_ori: wb_imm(cpu_pkg::alu_or, imm_zext);
			cpu_pkg::op_xori: wb_imm(cpu_pkg::alu_xor, imm_zext);
			cpu_pkg::op_lui: wb_imm(cpu_pkg::alu_setu, {instr[15:0], 16'h0});
			cpu_pkg::op_lw: mem_access(cpu_pkg::mem_lw);
			cpu_pkg::op_sw: mem_access(cpu_pkg::mem_sw);
			default: mark_invalid();
		endcase
	endtask

	always_ff @(posedge clk) begin
		set_bubble();	// Overridden below when a word is decoded
		invalid_pulse <= 1'b0;
		if (rst) begin
			if_branch <= 1'b0;
		end else if (drop) begin
			if_branch <= 1'b0;
		end else if (!stall) begin
			if_branch <= is_branch;
			do_decode();
		end
	end

	// Clear only meets a load hazard when a branch sits in a delay slot
	a_stall_clear_apart: assert property (@(posedge clk) disable iff (rst)
		!(stall && clear))
		else $error("stall and clear active in the same cycle");

endmodule

/* verilog/stage_if.sv */
`timescale 1ns/10ps

// Fetch: pc, instruction memory and the IF/ID register
module stage_if (
	input logic clk,
	input logic rst,
	input logic imem_we,
	input logic [cpu_pkg::IMEM_AW-1:0] imem_addr,
	input logic [31:0] imem_data,
	input logic stall,
	input logic branch_taken,
	input logic [31:0] branch_target,
	output logic [31:0] instr,
	output logic [31:0] next_pc	// Also the pc of the next fetch
);

	logic [31:0] imem [cpu_pkg::IMEM_WORDS];
	logic [31:0] fetch_addr;

	assign fetch_addr = branch_taken ? branch_target : next_pc;

	// Loaded by the testbench while the core sits in reset
	always_ff @(posedge clk) begin
		if (rst && imem_we)
			imem[imem_addr] <= imem_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			instr <= 32'h0;	// Decodes as a nop
			next_pc <= cpu_pkg::RESET_PC;
		end else if (branch_taken || !stall) begin
			instr <= imem[fetch_addr[cpu_pkg::IMEM_AW+1:2]];
			next_pc <= fetch_addr + 32'd4;
		end
	end

	// Program loading must finish before the core leaves reset
	a_imem_load_in_reset: assert property (@(posedge clk) imem_we |-> rst)
		else $error("imem_we high outside reset");

endmodule

/* verilog/register_file.sv */
`timescale 1ns/10ps

// 32 x 32 general purpose registers, r0 hardwired to zero
module register_file (
	input logic clk,
	input logic rst,
	input logic [4:0] read1_addr,
	input logic [4:0] read2_addr,
	input logic [4:0] write_addr,	// Zero means no write
	input logic [31:0] data_in,
	output logic [31:0] data_out1,
	output logic [31:0] data_out2
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'h0;
		end else if (write_addr != 5'd0) begin
			regs[write_addr] <= data_in;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0)
			return 32'h0;
		if (addr == write_addr)
			return data_in;
		return regs[addr];
	endfunction

	always_comb data_out1 = read_port(read1_addr);
	always_comb data_out2 = read_port(read2_addr);

endmodule

/* verilog/cpu_pkg.sv */
// Shared encodings and sizes for the five-stage core
package cpu_pkg;

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int IMEM_AW = $clog2(IMEM_WORDS);	// Word address width
	localparam int DMEM_AW = $clog2(DMEM_WORDS);
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	typedef enum logic [3:0] {
		alu_disable,	// Result forced to zero
		alu_addu,
		alu_subu,
		alu_and,
		alu_or,
		alu_xor,
		alu_lt,
		alu_ltu,
		alu_sll,
		alu_srl,
		alu_setu,	// Pass the immediate
		alu_pass_opr1
	} alu_op_e;

	typedef enum logic {
		src_reg,
		src_imm
	} alu_src_e;

	// Branches test whether the ALU result is zero
	typedef enum logic [2:0] {
		br_none,
		br_uncond,
		br_on_alu_eqz,
		br_on_alu_nez
	} branch_op_e;

	typedef enum logic [1:0] {
		mem_none,
		mem_lw,
		mem_sw
	} mem_op_e;

	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_regimm = 6'h01,
		op_j = 6'h02,
		op_jal = 6'h03,
		op_beq = 6'h04,
		op_bne = 6'h05,
		op_blez = 6'h06,
		op_bgtz = 6'h07,
		op_addiu = 6'h09,
		op_slti = 6'h0a,
		op_sltiu = 6'h0b,
		op_andi = 6'h0c,
		op_ori = 6'h0d,
		op_xori = 6'h0e,
		op_lui = 6'h0f,
		op_lw = 6'h23,
		op_sw = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fn_sll = 6'h00,
		fn_srl = 6'h02,
		fn_jr = 6'h08,
		fn_jalr = 6'h09,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and = 6'h24,
		fn_or = 6'h25,
		fn_xor = 6'h26,
		fn_slt = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

endpackage
